//--- build.f
scrub_pkg.sv
shell_ctl_regs.sv
ddr_scrubber.sv
scrub_status.sv
cl_scrub_top.sv
tb_cl_scrub.sv

//--- cl_scrub_top.sv
`timescale 1ns/1ns

module cl_scrub_top
(
   input  logic                                      clk,
   input  logic                                      sync_rst_n,

   // --------------------
   // Shell control side
   // --------------------
   input  scrub_pkg::word_t                          sh_cl_ctl0,
   input  logic [scrub_pkg::NUM_DDR-1:0]             sh_cl_ddr_is_ready,
   input  logic                                      sh_cl_flr_assert,
   output logic                                      cl_sh_flr_done,

   // --------------------
   // Scrub commands, one per channel
   // --------------------
   input  logic [scrub_pkg::NUM_DDR-1:0]             scrb_cmd_ready,
   output logic [scrub_pkg::NUM_DDR-1:0]             scrb_cmd_valid,
   output scrub_pkg::addr_t [scrub_pkg::NUM_DDR-1:0] scrb_cmd_addr,

   // --------------------
   // Status and ID words
   // --------------------
   output scrub_pkg::word_t                          cl_sh_status0,
   output scrub_pkg::word_t                          cl_sh_status1,
   output scrub_pkg::word_t                          cl_sh_id0,
   output scrub_pkg::word_t                          cl_sh_id1
);

   import scrub_pkg::*;

   word_t                      ctl_q;
   logic [NUM_DDR-1:0]         ddr_ready_q;
   scrb_state_t [NUM_DDR-1:0]  scrb_state;
   logic [NUM_DDR-1:0]         scrb_done;

   // Version word never changes
   assign cl_sh_status1 = CL_VERSION;

   // Control word, ready bits and FLR answer
   shell_ctl_regs u_ctl_regs
   (
      .clk                (clk),
      .sync_rst_n         (sync_rst_n),
      .sh_cl_ctl0         (sh_cl_ctl0),
      .sh_cl_ddr_is_ready (sh_cl_ddr_is_ready),
      .sh_cl_flr_assert   (sh_cl_flr_assert),
      .ctl_q              (ctl_q),
      .ddr_ready_q        (ddr_ready_q),
      .cl_sh_flr_done     (cl_sh_flr_done)
   );

   // --------------------
   // Channel scrubbers
   // --------------------

   // Control bit i enables channel i
   for (genvar i = 0; i < NUM_DDR; i++)
   begin : g_scrub
      ddr_scrubber u_scrubber
      (
         .clk        (clk),
         .sync_rst_n (sync_rst_n),
         .enable     (ctl_q[i]),
         .cmd_ready  (scrb_cmd_ready[i]),
         .cmd_valid  (scrb_cmd_valid[i]),
         .cmd_addr   (scrb_cmd_addr[i]),
         .state      (scrb_state[i]),
         .done       (scrb_done[i])
      );
   end

   // --------------------
   // Status readout
   // --------------------

   // Current command address doubles as the scrub position
   scrub_status u_status
   (
      .clk           (clk),
      .sync_rst_n    (sync_rst_n),
      .ctl_q         (ctl_q),
      .ddr_ready_q   (ddr_ready_q),
      .scrb_state    (scrb_state),
      .scrb_addr     (scrb_cmd_addr),
      .scrb_done     (scrb_done),
      .cl_sh_status0 (cl_sh_status0),
      .cl_sh_id0     (cl_sh_id0),
      .cl_sh_id1     (cl_sh_id1)
   );

endmodule

//--- ddr_scrubber.sv
`timescale 1ns/1ns

module ddr_scrubber
(
   input  logic                   clk,
   input  logic                   sync_rst_n,

   // Channel enable from the control word
   input  logic                   enable,

   // Burst write command, valid/ready
   input  logic                   cmd_ready,
   output logic                   cmd_valid,
   output scrub_pkg::addr_t       cmd_addr,

   // Progress for the status block
   output scrub_pkg::scrb_state_t state,
   output logic                   done
);

   import scrub_pkg::*;

   scrb_state_t state_nxt;
   addr_t       addr_nxt;
   addr_t       step_addr;
   logic        xfer;

   // Command goes out only while issuing
   assign cmd_valid = (state == SCRB_ISSUE);
   assign done      = (state == SCRB_DONE);

   // Transfer happens on valid and ready together
   assign xfer = cmd_valid && cmd_ready;

   // Start of the next burst
   assign step_addr = cmd_addr + addr_t'(SCRB_BURST_BYTES);

   // --------------------
   // Next state and address
   // --------------------
   always_comb
   begin
      state_nxt = state;
      addr_nxt  = cmd_addr;

      if (!enable)
      begin
         // Losing the enable restarts the walk from zero
         state_nxt = SCRB_IDLE;
         addr_nxt  = '0;
      end
      else
      begin
         case (state)
            SCRB_IDLE:
            begin
               state_nxt = SCRB_ISSUE;
               addr_nxt  = '0;
            end

            SCRB_ISSUE:
            begin
               // Address is only touched on a transfer, stalls leave it alone
               if (xfer)
               begin
                  if (step_addr > SCRB_MAX_ADDR)
                  begin
                     // Last burst sent, keep its address for debug readout
                     state_nxt = SCRB_DONE;
                  end
                  else
                  begin
                     state_nxt = SCRB_WAIT;
                     addr_nxt  = step_addr;
                  end
               end
            end

            // One idle cycle between commands
            SCRB_WAIT:
            begin
               state_nxt = SCRB_ISSUE;
            end

            // Stays finished until the enable drops
            SCRB_DONE:
            begin
               state_nxt = SCRB_DONE;
            end

            default:
            begin
               state_nxt = SCRB_IDLE;
               addr_nxt  = '0;
            end
         endcase
      end
   end

   // --------------------
   // State and address registers
   // --------------------
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         state    <= SCRB_IDLE;
         cmd_addr <= '0;
      end
      else
      begin
         state    <= state_nxt;
         cmd_addr <= addr_nxt;
      end
   end

endmodule

//--- scrub_pkg.sv
package scrub_pkg;

   // --------------------
   // Channel and bus widths
   // --------------------

   // Memory channels served by the scrubbers
   localparam int NUM_DDR = 4;

   localparam int ADDR_W = 64;
   localparam int WORD_W = 32;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [WORD_W-1:0] word_t;

   // --------------------
   // Burst geometry
   // --------------------

   // Bytes moved by one data beat
   localparam int BEAT_BYTES = 64;

   // AXI style length field, 16 beats per burst
   localparam int SCRB_BURST_LEN_MINUS1 = 15;

   // Address step between two scrub commands
   localparam int SCRB_BURST_BYTES = (SCRB_BURST_LEN_MINUS1 + 1) * BEAT_BYTES;

   // Small window so a full pass stays short, 8 bursts per channel
   localparam addr_t SCRB_MAX_ADDR = 64'h1FFF;

   // --------------------
   // Scrubber states
   // --------------------
   typedef enum logic [2:0]
   {
      SCRB_IDLE  = 3'd0,
      SCRB_ISSUE = 3'd1,
      SCRB_WAIT  = 3'd2,
      SCRB_DONE  = 3'd3
   } scrb_state_t;

   // --------------------
   // Control word layout
   // --------------------

   // Bits NUM_DDR-1 down to 0 enable the channel scrubbers
   localparam int CTL_DBG_EN_BIT = 31;
   localparam int CTL_DBG_SEL_HI = 30;
   localparam int CTL_DBG_SEL_LO = 28;

   // --------------------
   // Fixed status and ID words
   // --------------------
   localparam logic [19:0] STATUS_SIGNATURE = 20'hA1111;

   localparam word_t CL_ID0     = 32'hF000_1D0F;
   localparam word_t CL_ID1     = 32'h1D51_FEDD;
   localparam word_t CL_VERSION = 32'hEEEE_EE00;

endpackage

//--- scrub_status.sv
`timescale 1ns/1ns

module scrub_status
(
   input  logic                                          clk,
   input  logic                                          sync_rst_n,

   // Registered shell inputs
   input  scrub_pkg::word_t                              ctl_q,
   input  logic [scrub_pkg::NUM_DDR-1:0]                 ddr_ready_q,

   // Per channel scrub progress
   input  scrub_pkg::scrb_state_t [scrub_pkg::NUM_DDR-1:0] scrb_state,
   input  scrub_pkg::addr_t [scrub_pkg::NUM_DDR-1:0]     scrb_addr,
   input  logic [scrub_pkg::NUM_DDR-1:0]                 scrb_done,

   // Words read back by the shell
   output scrub_pkg::word_t                              cl_sh_status0,
   output scrub_pkg::word_t                              cl_sh_id0,
   output scrub_pkg::word_t                              cl_sh_id1
);

   import scrub_pkg::*;

   logic                                     dbg_en;
   logic [CTL_DBG_SEL_HI-CTL_DBG_SEL_LO:0]   dbg_sel;
   logic [4*NUM_DDR-1:0]                     state_nib;
   addr_t                                    sel_addr;
   word_t                                    status_norm;
   word_t                                    status_dbg;

   assign dbg_en  = ctl_q[CTL_DBG_EN_BIT];
   assign dbg_sel = ctl_q[CTL_DBG_SEL_HI:CTL_DBG_SEL_LO];

   // --------------------
   // Status0 layouts
   // --------------------

   // One nibble per channel, highest channel on top
   always_comb
   begin
      state_nib = '0;
      for (int i = 0; i < NUM_DDR; i++)
      begin
         state_nib[4*i +: 4] = {1'b0, scrb_state[i]};
      end
   end

   assign status_norm = {STATUS_SIGNATURE, 4'hF, scrb_done, ddr_ready_q};
   assign status_dbg  = {state_nib, 4'h0, 4'hF, scrb_done, ddr_ready_q};

   // Debug channel mux, out of range selects fall back to channel 0
   always_comb
   begin
      sel_addr = scrb_addr[0];
      for (int i = 1; i < NUM_DDR; i++)
      begin
         if (dbg_sel == i)
            sel_addr = scrb_addr[i];
      end
   end

   // --------------------
   // Output registers
   // --------------------
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         cl_sh_status0 <= '0;
         cl_sh_id0     <= '0;
         cl_sh_id1     <= '0;
      end
      else
      begin
         cl_sh_status0 <= dbg_en ? status_dbg : status_norm;
         // Low and high halves of the selected scrub address
         cl_sh_id0     <= dbg_en ? sel_addr[WORD_W-1:0] : CL_ID0;
         cl_sh_id1     <= dbg_en ? sel_addr[ADDR_W-1:WORD_W] : CL_ID1;
      end
   end

endmodule

//--- scrub_vectors.txt
# name wait ctl0 ddr_ready status0 id0 id1 (all values hex)
# wait=1 polls the status0 done bits, wait=0 samples two cycles after the write

# ID words and ready reporting with debug off
first_write   0 00000000 0 A1111F00 F0001D0F 1D51FEDD
ready_a       0 00000000 5 A1111F05 F0001D0F 1D51FEDD
ready_b       0 00000000 A A1111F0A F0001D0F 1D51FEDD
ready_all     0 00000000 F A1111F0F F0001D0F 1D51FEDD
ready_none    0 00000000 0 A1111F00 F0001D0F 1D51FEDD

# Single channels under back-pressure
scrub_ch0     1 00000001 F A1111F1F F0001D0F 1D51FEDD
scrub_ch2     1 00000005 3 A1111F53 F0001D0F 1D51FEDD

# Debug readout, held final address on finished channels
dbg_ch0       0 80000005 3 03030F53 00001C00 00000000
dbg_ch2       0 A0000005 3 03030F53 00001C00 00000000
dbg_ch1       0 90000005 3 03030F53 00000000 00000000
dbg_sel7      0 F0000005 3 03030F53 00001C00 00000000
dbg_off       0 00000005 3 A1111F53 F0001D0F 1D51FEDD

# Clearing the enables clears done
scrub_clear   1 00000000 3 A1111F03 F0001D0F 1D51FEDD

# All four channels at once
scrub_all     1 0000000F F A1111FFF F0001D0F 1D51FEDD
dbg_ch3       0 B000000F F 33330FFF 00001C00 00000000

# Partial clear, then a fresh walk on channel 0
part_clear    1 0000000A F A1111FAF F0001D0F 1D51FEDD
dbg_idle      0 8000000A 6 30300FA6 00000000 00000000
rescrub_ch0   1 8000000B 6 30330FB6 00001C00 00000000
final_clear   1 00000000 0 A1111F00 F0001D0F 1D51FEDD

//--- shell_ctl_regs.sv
`timescale 1ns/1ns

module shell_ctl_regs
(
   input  logic                            clk,
   input  logic                            sync_rst_n,

   // Raw inputs from the shell
   input  scrub_pkg::word_t                sh_cl_ctl0,
   input  logic [scrub_pkg::NUM_DDR-1:0]   sh_cl_ddr_is_ready,
   input  logic                            sh_cl_flr_assert,

   // Registered copies for the rest of the design
   output scrub_pkg::word_t                ctl_q,
   output logic [scrub_pkg::NUM_DDR-1:0]   ddr_ready_q,

   // Function level reset answer
   output logic                            cl_sh_flr_done
);

   import scrub_pkg::*;

   logic flr_assert_q;

   // --------------------
   // Control and ready capture
   // --------------------

   // Enables, debug select and ready bits all move one cycle late
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         ctl_q       <= {WORD_W{1'b0}};
         ddr_ready_q <= {NUM_DDR{1'b0}};
      end
      else
      begin
         ctl_q       <= sh_cl_ctl0;
         ddr_ready_q <= sh_cl_ddr_is_ready;
      end
   end

   // --------------------
   // FLR response
   // --------------------

   // Request is staged once, done follows one cycle later.
   // A held request makes done toggle, so it pulses every other cycle
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         flr_assert_q   <= 1'b0;
         cl_sh_flr_done <= 1'b0;
      end
      else
      begin
         flr_assert_q   <= sh_cl_flr_assert;
         cl_sh_flr_done <= flr_assert_q && !cl_sh_flr_done;
      end
   end

endmodule

//--- tb_cl_scrub.sv
`timescale 1ns/1ns

module tb_cl_scrub;

   localparam int NCH        = 4;
   localparam int CLK_HALF   = 50;
   localparam int RST_CYCLES = 16;

   // 16 beats of 64 bytes per burst, addresses 0 to 0x1C00
   localparam logic [63:0] BURST_STEP    = 64'd1024;
   localparam int          BURSTS_PER_CH = 8;
   localparam logic [31:0] VERSION_WORD  = 32'hEEEE_EE00;

   logic                  clk;
   logic                  sync_rst_n;
   logic [31:0]           sh_cl_ctl0;
   logic [NCH-1:0]        sh_cl_ddr_is_ready;
   logic                  sh_cl_flr_assert;
   logic                  cl_sh_flr_done;
   logic [NCH-1:0]        scrb_cmd_ready;
   logic [NCH-1:0]        scrb_cmd_valid;
   logic [NCH-1:0][63:0]  scrb_cmd_addr;
   logic [31:0]           cl_sh_status0;
   logic [31:0]           cl_sh_status1;
   logic [31:0]           cl_sh_id0;
   logic [31:0]           cl_sh_id1;

   // Vector table
   string       vec_name[$];
   logic        vec_wait[$];
   logic [31:0] vec_ctl[$];
   logic [3:0]  vec_ready[$];
   logic [31:0] vec_status0[$];
   logic [31:0] vec_id0[$];
   logic [31:0] vec_id1[$];
   int          num_vectors = 0;

   // Command monitor state
   string       cur_name;
   int          cmd_count [NCH];
   logic        pend [NCH];
   logic [63:0] pend_addr [NCH];

   cl_scrub_top DUT
   (
      .clk                (clk),
      .sync_rst_n         (sync_rst_n),
      .sh_cl_ctl0         (sh_cl_ctl0),
      .sh_cl_ddr_is_ready (sh_cl_ddr_is_ready),
      .sh_cl_flr_assert   (sh_cl_flr_assert),
      .cl_sh_flr_done     (cl_sh_flr_done),
      .scrb_cmd_ready     (scrb_cmd_ready),
      .scrb_cmd_valid     (scrb_cmd_valid),
      .scrb_cmd_addr      (scrb_cmd_addr),
      .cl_sh_status0      (cl_sh_status0),
      .cl_sh_status1      (cl_sh_status1),
      .cl_sh_id0          (cl_sh_id0),
      .cl_sh_id1          (cl_sh_id1)
   );

   always #CLK_HALF clk = ~clk;

   // --------------------
   // Helpers
   // --------------------
   task automatic check(input string name, input logic [63:0] expected,
                        input logic [63:0] actual);
      if (expected !== actual)
      begin
         $display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual);
         $display("SOME TESTS FAILED");
         $fatal(1);
      end
   endtask

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("SOME TESTS FAILED");
      $fatal(1);
   endtask

   task automatic load_vectors();
      int          fd;
      int          n;
      string       line;
      string       name;
      logic [31:0] wait_f;
      logic [31:0] ctl_f;
      logic [31:0] rdy_f;
      logic [31:0] st_f;
      logic [31:0] i0_f;
      logic [31:0] i1_f;
      fd = $fopen("scrub_vectors.txt", "r");
      if (fd == 0)
         abort_run("Could not open scrub_vectors.txt");
      while ($fgets(line, fd) != 0)
      begin
         // Skip blank lines and comments
         if (line.len() < 2 || line[0] == "#")
            continue;
         n = $sscanf(line, "%s %h %h %h %h %h %h", name, wait_f, ctl_f, rdy_f, st_f, i0_f, i1_f);
         if (n != 7)
            abort_run({"Malformed line in scrub_vectors.txt: ", line});
         vec_name.push_back(name);
         vec_wait.push_back(wait_f[0]);
         vec_ctl.push_back(ctl_f);
         vec_ready.push_back(rdy_f[3:0]);
         vec_status0.push_back(st_f);
         vec_id0.push_back(i0_f);
         vec_id1.push_back(i1_f);
      end
      $fclose(fd);
      if (vec_name.size() == 0)
         abort_run("No vectors found in scrub_vectors.txt");
      num_vectors = vec_name.size();
   endtask

   // --------------------
   // Back-pressure and watchdog
   // --------------------

   // Each ready bit is high about half the time
   initial
   begin
      scrb_cmd_ready = '0;
      void'($urandom(98425));
      forever
      begin
         @(negedge clk);
         scrb_cmd_ready = 4'($urandom);
      end
   end

   initial
   begin
      wait (num_vectors > 0);
      repeat ((num_vectors + 1) * 2000 + RST_CYCLES) @(posedge clk);
      $display("Timeout: the run did not finish within the expected number of cycles");
      $display("SOME TESTS FAILED");
      $fatal(1);
   end

   // --------------------
   // Command monitor
   // --------------------

   // Checks order, address and hold of every burst command
   always @(posedge clk)
   begin
      int ch;
      if (sync_rst_n)
      begin
         for (ch = 0; ch < NCH; ch++)
         begin
            if (pend[ch])
            begin
               check($sformatf("%s_hold_valid_ch%0d", cur_name, ch), 1, scrb_cmd_valid[ch]);
               check($sformatf("%s_hold_addr_ch%0d", cur_name, ch), pend_addr[ch],
                     scrb_cmd_addr[ch]);
            end
            if (scrb_cmd_valid[ch] && scrb_cmd_ready[ch])
            begin
               if (cmd_count[ch] >= BURSTS_PER_CH)
                  abort_run($sformatf("Channel %0d sent a command after its last burst in %s",
                                      ch, cur_name));
               check($sformatf("%s_cmd_addr_ch%0d", cur_name, ch),
                     BURST_STEP * cmd_count[ch], scrb_cmd_addr[ch]);
               cmd_count[ch]++;
            end
            pend[ch]      = scrb_cmd_valid[ch] && !scrb_cmd_ready[ch];
            pend_addr[ch] = scrb_cmd_addr[ch];
         end
      end
   end

   // --------------------
   // Test steps
   // --------------------
   task automatic check_reset_values();
      check("reset_status0", 0, cl_sh_status0);
      check("reset_id0", 0, cl_sh_id0);
      check("reset_id1", 0, cl_sh_id1);
      check("reset_cmd_valid", 0, scrb_cmd_valid);
      check("reset_flr_done", 0, cl_sh_flr_done);
      check("reset_status1", VERSION_WORD, cl_sh_status1);
   endtask

   task automatic run_vector(input int i);
      int    ch;
      string name;
      name = vec_name[i];
      @(negedge clk);
      cur_name           = name;
      sh_cl_ctl0         = vec_ctl[i];
      sh_cl_ddr_is_ready = vec_ready[i];
      // A disabled channel restarts its walk from zero
      for (ch = 0; ch < NCH; ch++)
      begin
         if (!vec_ctl[i][ch])
            cmd_count[ch] = 0;
      end
      if (vec_wait[i])
      begin
         repeat (3) @(negedge clk);
         while (cl_sh_status0[7:4] !== vec_status0[i][7:4])
            @(negedge clk);
      end
      else
      begin
         repeat (2) @(negedge clk);
      end
      check({name, "_status0"}, vec_status0[i], cl_sh_status0);
      check({name, "_id0"}, vec_id0[i], cl_sh_id0);
      check({name, "_id1"}, vec_id1[i], cl_sh_id1);
      check({name, "_status1"}, VERSION_WORD, cl_sh_status1);
      if (vec_wait[i])
      begin
         for (ch = 0; ch < NCH; ch++)
         begin
            if (vec_status0[i][4+ch])
            begin
               check($sformatf("%s_cmd_count_ch%0d", name, ch), BURSTS_PER_CH, cmd_count[ch]);
               check($sformatf("%s_idle_valid_ch%0d", name, ch), 0, scrb_cmd_valid[ch]);
            end
         end
      end
   endtask

   task automatic run_flr();
      int k;
      cur_name = "flr";
      @(negedge clk);
      check("flr_done_before", 0, cl_sh_flr_done);
      sh_cl_flr_assert = 1'b1;
      @(negedge clk);
      check("flr_done_cycle1", 0, cl_sh_flr_done);
      @(negedge clk);
      check("flr_done_cycle2", 1, cl_sh_flr_done);
      // Shell drops the request once done is seen
      sh_cl_flr_assert = 1'b0;
      for (k = 0; k < 6; k++)
      begin
         @(negedge clk);
         check("flr_done_after_release", 0, cl_sh_flr_done);
      end
   endtask

   // --------------------
   // Main sequence
   // --------------------
   initial
   begin
      int i;
      int ch;
      clk                = 1'b0;
      sync_rst_n         = 1'b0;
      sh_cl_ctl0         = '0;
      sh_cl_ddr_is_ready = '0;
      sh_cl_flr_assert   = 1'b0;
      cur_name           = "reset";
      for (ch = 0; ch < NCH; ch++)
      begin
         cmd_count[ch] = 0;
         pend[ch]      = 1'b0;
         pend_addr[ch] = '0;
      end
      load_vectors();
      repeat (RST_CYCLES) @(negedge clk);
      check_reset_values();
      sync_rst_n = 1'b1;
      for (i = 0; i < num_vectors; i++)
         run_vector(i);
      run_flr();
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule
